// ==== traffic_limiter.f ====
src/limiter_pkg.sv
src/cmd_gate.sv
src/pending_counter.sv
src/traffic_limiter.sv
sim/traffic_limiter_chk.sv
sim/traffic_limiter_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the traffic limiter testbench with Verilator and run it
# exit status is nonzero unless the simulation reports success

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
   --top-module traffic_limiter_tb -f traffic_limiter.f &&
./obj_dir/Vtraffic_limiter_tb | tee /dev/stderr | grep "TESTBENCH PASSED" > /dev/null &&
echo "simulation ok" ||
{ echo "simulation not ok"; exit 1; }

// ==== sim/traffic_limiter_tb.sv ====
// testbench for the traffic limiter, random master and slave traffic checked against a model
`default_nettype none
`timescale 1ns/10ps

module traffic_limiter_tb;

   import limiter_pkg::*;

   // ----------------------------------------------------------------------
   // run length and signals
   // ----------------------------------------------------------------------

   // random traffic phase, then drain and the underflow phase
   localparam int stim_cycles = 3000;
   localparam int max_cycles  = 4000;

   logic              clk;
   logic              reset;
   logic              cmd_sink_valid;
   logic [data_w-1:0] cmd_sink_data;
   logic              cmd_sink_startofpacket;
   logic              cmd_sink_endofpacket;
   logic              cmd_sink_ready;
   logic              cmd_src_valid;
   logic [data_w-1:0] cmd_src_data;
   logic              cmd_src_startofpacket;
   logic              cmd_src_endofpacket;
   logic              cmd_src_ready;
   logic              rsp_sink_valid;
   logic [data_w-1:0] rsp_sink_data;
   logic              rsp_sink_startofpacket;
   logic              rsp_sink_endofpacket;
   logic              rsp_sink_ready;
   logic              rsp_src_valid;
   logic [data_w-1:0] rsp_src_data;
   logic              rsp_src_startofpacket;
   logic              rsp_src_endofpacket;
   logic              rsp_src_ready;
   logic              rsp_underflow;

   int seed   = 44291;
   int errors = 0;
   int checks = 0;
   int cycle  = 0;
   bit stim_done;
   logic [dest_id_w-1:0] prev_dest;

   // reference model state, as it will be after the next rising edge
   int                   model_count;
   logic [dest_id_w-1:0] model_last_dest;
   logic                 model_underflow;

   // slaves owed a response, in command order
   logic [dest_id_w-1:0] rsp_dest [64];
   logic [5:0]           wr_ptr = '0;
   logic [5:0]           rd_ptr = '0;

   traffic_limiter i_dut (
      .clk                    (clk),
      .reset                  (reset),
      .cmd_sink_valid         (cmd_sink_valid),
      .cmd_sink_data          (cmd_sink_data),
      .cmd_sink_startofpacket (cmd_sink_startofpacket),
      .cmd_sink_endofpacket   (cmd_sink_endofpacket),
      .cmd_sink_ready         (cmd_sink_ready),
      .cmd_src_valid          (cmd_src_valid),
      .cmd_src_data           (cmd_src_data),
      .cmd_src_startofpacket  (cmd_src_startofpacket),
      .cmd_src_endofpacket    (cmd_src_endofpacket),
      .cmd_src_ready          (cmd_src_ready),
      .rsp_sink_valid         (rsp_sink_valid),
      .rsp_sink_data          (rsp_sink_data),
      .rsp_sink_startofpacket (rsp_sink_startofpacket),
      .rsp_sink_endofpacket   (rsp_sink_endofpacket),
      .rsp_sink_ready         (rsp_sink_ready),
      .rsp_src_valid          (rsp_src_valid),
      .rsp_src_data           (rsp_src_data),
      .rsp_src_startofpacket  (rsp_src_startofpacket),
      .rsp_src_endofpacket    (rsp_src_endofpacket),
      .rsp_src_ready          (rsp_src_ready),
      .rsp_underflow          (rsp_underflow)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= max_cycles) begin
         $display("timeout: run did not finish within %0d cycles", max_cycles);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   // ----------------------------------------------------------------------
   // helpers
   // ----------------------------------------------------------------------

   function automatic int rand_below(input int n);
      int r;
      r = $random(seed) & 32'h7fffffff;
      return r % n;
   endfunction

   task automatic check_value(input string name, input logic [data_w-1:0] expected,
                              input logic [data_w-1:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("error: %s expected %h actual %h at %0t", name, expected, actual, $time);
      end
   endtask

   // one master packet, header repeated in every beat
   task automatic send_packet();
      int                   beats;
      logic [dest_id_w-1:0] dest;
      logic                 posted;
      logic                 write;
      logic [data_w-1:0]    beat;
      bit                   accepted;
      beats = 1 + rand_below(3);
      // reuse the last slave half the time so the limit gets reached
      if (rand_below(2) == 0) begin
         dest = prev_dest;
      end else begin
         dest = dest_id_w'(rand_below(4));
      end
      posted = (rand_below(3) == 0);
      write  = (rand_below(2) == 0);
      for (int i = 0; i < beats; i++) begin
         repeat (rand_below(3)) begin
            @(posedge clk);
            #1;
         end
         beat = $random(seed);
         beat[dest_id_lo +: dest_id_w] = dest;
         beat[trans_posted_bit] = posted;
         beat[trans_write_bit]  = write;
         cmd_sink_valid         = 1'b1;
         cmd_sink_data          = beat;
         cmd_sink_startofpacket = (i == 0);
         cmd_sink_endofpacket   = (i == beats - 1);
         accepted = 1'b0;
         // ready sampled mid-cycle, where it is settled
         while (!accepted) begin
            @(negedge clk);
            accepted = cmd_sink_ready;
            @(posedge clk);
            #1;
         end
         cmd_sink_valid = 1'b0;
      end
      prev_dest = dest;
   endtask

   // one slave response packet carrying the slave id as source
   task automatic send_response(input logic [dest_id_w-1:0] src);
      int                beats;
      logic [data_w-1:0] beat;
      bit                accepted;
      beats = 1 + rand_below(2);
      for (int i = 0; i < beats; i++) begin
         beat = $random(seed);
         beat[src_id_lo +: dest_id_w] = src;
         rsp_sink_valid         = 1'b1;
         rsp_sink_data          = beat;
         rsp_sink_startofpacket = (i == 0);
         rsp_sink_endofpacket   = (i == beats - 1);
         accepted = 1'b0;
         while (!accepted) begin
            @(negedge clk);
            accepted = rsp_sink_ready;
            @(posedge clk);
            #1;
         end
         rsp_sink_valid = 1'b0;
      end
   endtask

   // ----------------------------------------------------------------------
   // reference model and checks, once per cycle at the falling edge
   // ----------------------------------------------------------------------

   always @(negedge clk) begin : model_check
      logic [dest_id_w-1:0] dest;
      logic                 np;
      logic                 suppress;
      logic                 exp_valid;
      logic                 exp_ready;
      logic                 cmd_np_end;
      logic                 rsp_end;
      if (reset) begin
         model_count     = 0;
         model_last_dest = '0;
         model_underflow = 1'b0;
      end else begin
         dest = cmd_sink_data[dest_id_lo +: dest_id_w];
         np   = ~cmd_sink_data[trans_posted_bit];
         // held when switching slaves with responses out, or when full
         suppress = np && ((model_count != 0 && dest != model_last_dest) ||
                           model_count == max_outstanding);
         exp_valid = cmd_sink_valid & ~suppress;
         exp_ready = cmd_src_ready & ~suppress;
         check_value("cmd_src_valid", data_w'(exp_valid), data_w'(cmd_src_valid));
         check_value("cmd_sink_ready", data_w'(exp_ready), data_w'(cmd_sink_ready));
         check_value("cmd_src_data", cmd_sink_data, cmd_src_data);
         check_value("cmd_src_startofpacket", data_w'(cmd_sink_startofpacket),
                     data_w'(cmd_src_startofpacket));
         check_value("cmd_src_endofpacket", data_w'(cmd_sink_endofpacket),
                     data_w'(cmd_src_endofpacket));
         // response side is a plain pass-through
         check_value("rsp_src_valid", data_w'(rsp_sink_valid), data_w'(rsp_src_valid));
         check_value("rsp_src_data", rsp_sink_data, rsp_src_data);
         check_value("rsp_src_startofpacket", data_w'(rsp_sink_startofpacket),
                     data_w'(rsp_src_startofpacket));
         check_value("rsp_src_endofpacket", data_w'(rsp_sink_endofpacket),
                     data_w'(rsp_src_endofpacket));
         check_value("rsp_sink_ready", data_w'(rsp_src_ready), data_w'(rsp_sink_ready));
         check_value("rsp_underflow", data_w'(model_underflow), data_w'(rsp_underflow));
         // what transfers on the coming edge
         cmd_np_end = cmd_sink_valid && exp_ready && np && cmd_sink_endofpacket;
         rsp_end    = rsp_sink_valid && rsp_src_ready && rsp_sink_endofpacket;
         if (cmd_sink_valid && exp_ready && np) begin
            model_last_dest = dest;
         end
         if (cmd_np_end) begin
            rsp_dest[wr_ptr] = dest;
            wr_ptr = wr_ptr + 6'd1;
         end
         if (rsp_end && model_count == 0) begin
            model_underflow = 1'b1;
         end
         if (cmd_np_end && !rsp_end) begin
            model_count++;
         end else if (rsp_end && !cmd_np_end && model_count != 0) begin
            model_count--;
         end
      end
   end

   // ----------------------------------------------------------------------
   // stimulus
   // ----------------------------------------------------------------------

   initial begin
      reset                  = 1'b1;
      cmd_sink_valid         = 1'b0;
      cmd_sink_data          = '0;
      cmd_sink_startofpacket = 1'b0;
      cmd_sink_endofpacket   = 1'b0;
      cmd_src_ready          = 1'b0;
      rsp_sink_valid         = 1'b0;
      rsp_sink_data          = '0;
      rsp_sink_startofpacket = 1'b0;
      rsp_sink_endofpacket   = 1'b0;
      rsp_src_ready          = 1'b0;
      stim_done              = 1'b0;
      prev_dest              = '0;
      repeat (16) @(posedge clk);
      #1;
      reset = 1'b0;
      fork
         begin : master
            while (cycle < stim_cycles) begin
               send_packet();
            end
            stim_done = 1'b1;
         end
         begin : slave
            while (!stim_done || rd_ptr != wr_ptr) begin
               if (rd_ptr != wr_ptr) begin
                  repeat (rand_below(12)) begin
                     @(posedge clk);
                     #1;
                  end
                  send_response(rsp_dest[rd_ptr]);
                  rd_ptr = rd_ptr + 6'd1;
               end else begin
                  @(posedge clk);
                  #1;
               end
            end
         end
         begin : stall
            // both src ports stall about a quarter of the time
            while (!stim_done) begin
               @(posedge clk);
               #1;
               cmd_src_ready = (rand_below(4) != 0);
               rsp_src_ready = (rand_below(4) != 0);
            end
            cmd_src_ready = 1'b1;
            rsp_src_ready = 1'b1;
         end
      join
      while (model_count != 0) begin
         @(negedge clk);
      end
      repeat (4) @(posedge clk);
      #1;
      // stray response with nothing outstanding, flag must stick
      send_response(dest_id_w'(0));
      while (!model_underflow) begin
         @(negedge clk);
      end
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b1;
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;
      repeat (4) @(posedge clk);
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule : traffic_limiter_tb

`default_nettype wire

// ==== sim/traffic_limiter_chk.sv ====
// handshake and status assertions, bound into the traffic limiter top level
`default_nettype none
`timescale 1ns/10ps

module traffic_limiter_chk (
   input logic                           clk,
   input logic                           reset,
   input logic [limiter_pkg::data_w-1:0] cmd_sink_data,
   input logic                           cmd_src_valid,
   input logic                           at_limit,
   input logic                           rsp_sink_ready,
   input logic                           rsp_src_ready,
   input logic                           rsp_underflow
);

   import limiter_pkg::*;

   logic np_beat;

   // beat on the sink expects a response
   assign np_beat = ~cmd_sink_data[trans_posted_bit];

   // ----------------------------------------------------------------------
   // command side
   // ----------------------------------------------------------------------

   // a full counter keeps every non-posted beat away from the slaves
   limit_holds_np : assert property (@(posedge clk) disable iff (reset)
      (at_limit && np_beat) |-> !cmd_src_valid)
      else $error("non-posted command reached the slaves at the outstanding limit");

   // ----------------------------------------------------------------------
   // response side
   // ----------------------------------------------------------------------

   // no buffering, so back-pressure goes straight through
   rsp_ready_follows : assert property (@(posedge clk) disable iff (reset)
      rsp_sink_ready == rsp_src_ready)
      else $error("response sink ready differs from response src ready");

   // sticky until reset
   underflow_sticky : assert property (@(posedge clk) disable iff (reset)
      rsp_underflow |=> rsp_underflow)
      else $error("response underflow flag cleared without reset");

endmodule : traffic_limiter_chk

bind traffic_limiter traffic_limiter_chk i_chk (
   .clk            (clk),
   .reset          (reset),
   .cmd_sink_data  (cmd_sink_data),
   .cmd_src_valid  (cmd_src_valid),
   .at_limit       (at_limit),
   .rsp_sink_ready (rsp_sink_ready),
   .rsp_src_ready  (rsp_src_ready),
   .rsp_underflow  (rsp_underflow)
);

`default_nettype wire

// ==== src/traffic_limiter.sv ====
// top level of the command/response traffic limiter between one master and the interconnect
`default_nettype none
`timescale 1ns/10ps

module traffic_limiter (
   input  logic                           clk,
   input  logic                           reset,

   // command from the master
   input  logic                           cmd_sink_valid,
   input  logic [limiter_pkg::data_w-1:0] cmd_sink_data,
   input  logic                           cmd_sink_startofpacket,
   input  logic                           cmd_sink_endofpacket,
   output logic                           cmd_sink_ready,

   // command toward the slaves
   output logic                           cmd_src_valid,
   output logic [limiter_pkg::data_w-1:0] cmd_src_data,
   output logic                           cmd_src_startofpacket,
   output logic                           cmd_src_endofpacket,
   input  logic                           cmd_src_ready,

   // response from the slaves
   input  logic                           rsp_sink_valid,
   input  logic [limiter_pkg::data_w-1:0] rsp_sink_data,
   input  logic                           rsp_sink_startofpacket,
   input  logic                           rsp_sink_endofpacket,
   output logic                           rsp_sink_ready,

   // response toward the master
   output logic                           rsp_src_valid,
   output logic [limiter_pkg::data_w-1:0] rsp_src_data,
   output logic                           rsp_src_startofpacket,
   output logic                           rsp_src_endofpacket,
   input  logic                           rsp_src_ready,

   // a response came back with nothing outstanding
   output logic                           rsp_underflow
);

   logic has_pending;
   logic at_limit;
   logic cmd_accept_eop_np;
   logic rsp_accept_eop;

   // ----------------------------------------------------------------------
   // command path
   // ----------------------------------------------------------------------

   cmd_gate i_cmd_gate (
      .clk                    (clk),
      .reset                  (reset),
      .cmd_sink_valid         (cmd_sink_valid),
      .cmd_sink_data          (cmd_sink_data),
      .cmd_sink_startofpacket (cmd_sink_startofpacket),
      .cmd_sink_endofpacket   (cmd_sink_endofpacket),
      .cmd_sink_ready         (cmd_sink_ready),
      .cmd_src_valid          (cmd_src_valid),
      .cmd_src_data           (cmd_src_data),
      .cmd_src_startofpacket  (cmd_src_startofpacket),
      .cmd_src_endofpacket    (cmd_src_endofpacket),
      .cmd_src_ready          (cmd_src_ready),
      .has_pending            (has_pending),
      .at_limit               (at_limit),
      .cmd_accept_eop_np      (cmd_accept_eop_np)
   );

   // ----------------------------------------------------------------------
   // response path
   // ----------------------------------------------------------------------

   // responses already come back in order, nothing to hold here
   assign rsp_src_valid         = rsp_sink_valid;
   assign rsp_src_data          = rsp_sink_data;
   assign rsp_src_startofpacket = rsp_sink_startofpacket;
   assign rsp_src_endofpacket   = rsp_sink_endofpacket;
   assign rsp_sink_ready        = rsp_src_ready;

   // one pulse per response packet, on its last beat
   assign rsp_accept_eop = rsp_sink_valid & rsp_sink_ready & rsp_sink_endofpacket;

   // ----------------------------------------------------------------------
   // outstanding count
   // ----------------------------------------------------------------------

   pending_counter i_pending_counter (
      .clk               (clk),
      .reset             (reset),
      .cmd_accept_eop_np (cmd_accept_eop_np),
      .rsp_accept_eop    (rsp_accept_eop),
      .has_pending       (has_pending),
      .at_limit          (at_limit),
      .rsp_underflow     (rsp_underflow)
   );

endmodule : traffic_limiter

`default_nettype wire

// ==== src/pending_counter.sv ====
// outstanding non-posted packet counter with pending, limit and underflow status
`default_nettype none
`timescale 1ns/10ps

module pending_counter (
   input  logic clk,
   input  logic reset,

   // end of an accepted non-posted command packet
   input  logic cmd_accept_eop_np,
   // end of an accepted response packet
   input  logic rsp_accept_eop,

   // registered status, valid one cycle after the accept edge
   output logic has_pending,
   output logic at_limit,
   // sticky, cleared only by reset
   output logic rsp_underflow
);

   import limiter_pkg::*;

   // ----------------------------------------------------------------------
   // next count
   // ----------------------------------------------------------------------

   logic [count_w-1:0] count;
   logic [count_w-1:0] next_count;
   logic               count_is_zero;
   logic               underflow_event;

   assign count_is_zero = (count == '0);

   // a response with nothing outstanding
   // nothing can have been sent that it answers
   assign underflow_event = rsp_accept_eop & count_is_zero;

   always_comb begin
      next_count = count;
      // command end and response end together cancel out
      if (cmd_accept_eop_np & ~rsp_accept_eop) begin
         next_count = count + 1'b1;
      end
      if (rsp_accept_eop & ~cmd_accept_eop_np) begin
         // stays at zero on a stray response
         // otherwise a wrap would read as a full counter
         if (!count_is_zero) begin
            next_count = count - 1'b1;
         end
      end
   end

   // ----------------------------------------------------------------------
   // registers
   // ----------------------------------------------------------------------

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         count       <= '0;
         has_pending <= 1'b0;
         at_limit    <= 1'b0;
      end else begin
         count       <= next_count;
         // status from next_count so it lines up with the new count
         has_pending <= (next_count != '0);
         at_limit    <= (next_count == count_w'(max_outstanding));
      end
   end

   // ----------------------------------------------------------------------
   // underflow flag
   // ----------------------------------------------------------------------

   // set on the edge of the stray response, visible the next cycle
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rsp_underflow <= 1'b0;
      end else if (underflow_event) begin
         rsp_underflow <= 1'b1;
      end
   end

endmodule : pending_counter

`default_nettype wire

// ==== src/cmd_gate.sv ====
// command path gate that holds back non-posted packets to a new slave or above the limit
`default_nettype none
`timescale 1ns/10ps

module cmd_gate (
   input  logic                           clk,
   input  logic                           reset,

   // command stream from the master
   input  logic                           cmd_sink_valid,
   input  logic [limiter_pkg::data_w-1:0] cmd_sink_data,
   input  logic                           cmd_sink_startofpacket,
   input  logic                           cmd_sink_endofpacket,
   output logic                           cmd_sink_ready,

   // command stream toward the interconnect
   output logic                           cmd_src_valid,
   output logic [limiter_pkg::data_w-1:0] cmd_src_data,
   output logic                           cmd_src_startofpacket,
   output logic                           cmd_src_endofpacket,
   input  logic                           cmd_src_ready,

   // status from the pending counter
   input  logic                           has_pending,
   input  logic                           at_limit,

   // pulse to the counter, one per accepted non-posted packet
   output logic                           cmd_accept_eop_np
);

   import limiter_pkg::*;

   // ----------------------------------------------------------------------
   // header decode
   // ----------------------------------------------------------------------

   logic [dest_id_w-1:0] dest_id;
   logic [dest_id_w-1:0] last_dest;
   logic                 nonposted;
   logic                 dest_changed;

   // header sits in every beat so decode straight off the sink
   assign dest_id   = cmd_sink_data[dest_id_lo +: dest_id_w];
   assign nonposted = ~cmd_sink_data[trans_posted_bit];

   // compare against the slave that the pending responses belong to
   assign dest_changed = (dest_id != last_dest);

   // ----------------------------------------------------------------------
   // suppression
   // ----------------------------------------------------------------------

   logic suppress_dest;
   logic suppress_max;
   logic suppress;

   // switching slaves with responses in flight could let the new slave
   // answer first, so hold the command until everything has come back
   assign suppress_dest = nonposted & has_pending & dest_changed;

   // no more room for another response
   assign suppress_max = nonposted & at_limit;

   // posted commands are never held
   assign suppress = suppress_dest | suppress_max;

   // valid and ready are masked together
   // a held beat is invisible downstream and stalled upstream
   assign cmd_src_valid  = cmd_sink_valid & ~suppress;
   assign cmd_sink_ready = cmd_src_ready & ~suppress;

   // payload and packet marks go straight through
   assign cmd_src_data          = cmd_sink_data;
   assign cmd_src_startofpacket = cmd_sink_startofpacket;
   assign cmd_src_endofpacket   = cmd_sink_endofpacket;

   // ----------------------------------------------------------------------
   // last destination
   // ----------------------------------------------------------------------

   logic np_beat_accepted;

   // a non-posted beat that actually moved on this edge
   // sink and src handshakes are the same event here, no buffering
   assign np_beat_accepted = cmd_sink_valid & cmd_sink_ready & nonposted;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         last_dest <= '0;
      end else if (np_beat_accepted) begin
         // while responses are pending this can only rewrite the same id
         last_dest <= dest_id;
      end
   end

   // ----------------------------------------------------------------------
   // packet end toward the counter
   // ----------------------------------------------------------------------

   // counted once per packet, on the end-of-packet beat
   // taken from the src side so a held beat never counts
   assign cmd_accept_eop_np = cmd_src_valid & cmd_src_ready & cmd_src_endofpacket
                              & nonposted;

endmodule : cmd_gate

`default_nettype wire

// ==== src/limiter_pkg.sv ====
// shared packet field positions and limits for the traffic limiter RTL and its testbench
`default_nettype none

package limiter_pkg;

   // ----------------------------------------------------------------------
   // packet beat layout
   // ----------------------------------------------------------------------

   // width of one beat on both the command and the response stream
   localparam int unsigned data_w = 32;

   // every command beat repeats the header fields, so the gate can look
   // at any beat of a packet and not only the first one
   //
   //   bit  4     posted flag
   //   bit  5     write flag
   //   bits 9:8   destination id
   //   bits 13:12 source id (response beats)
   //
   // the remaining bits are payload and pass through untouched

   // destination id of a command beat
   localparam int unsigned dest_id_lo = 8;
   localparam int unsigned dest_id_w = 2;

   // source id of a response beat
   // same width as the destination id, the slave copies its own id here
   localparam int unsigned src_id_lo = 12;

   // set for posted commands, which never get a response
   localparam int unsigned trans_posted_bit = 4;

   // read or write direction
   // not used by the gate, only carried for the traffic mix
   localparam int unsigned trans_write_bit = 5;

   // ----------------------------------------------------------------------
   // outstanding response limit
   // ----------------------------------------------------------------------

   // non-posted packets allowed in flight at once
   localparam int unsigned max_outstanding = 4;

   // counter must hold 0 .. max_outstanding inclusive
   localparam int unsigned count_w = $clog2(max_outstanding + 1);

endpackage : limiter_pkg

`default_nettype wire
